/* all.f */
source/vita_pkg.sv
source/vita_hdr_fsm.sv
source/vita_len_counter.sv
source/vita_sample_packer.sv
source/vita_sample_fifo.sv
source/vita_tx_deframer.sv
verif/tb_vita_tx_deframer.sv

/* verif/tb_vita_tx_deframer.sv */
`timescale 1ns/1ps

module tb_vita_tx_deframer;

   localparam int NPKT = 9;
   localparam int W    = vita_pkg::ENTRY_W;

   logic         clk = 1'b0;
   logic         rst_n;
   logic         clear;
   logic         set_stb;
   logic [7:0]   set_addr;
   logic [31:0]  set_data;
   logic [35:0]  in_data;
   logic         in_valid;
   logic         in_ready;
   logic [W-1:0] out_entry;
   logic         out_valid;
   logic         out_ready;

   logic [W-1:0] exp_entry [256];
   logic [W-1:0] exp_mask [256];   // unused channels keep stale samples
   int           exp_wr = 0;
   int           exp_rd = 0;
   logic [3:0]   prev_seq = 4'hf;
   int           ready_pct = 70;
   int           cur_nch = 1;
   int           cycles = 0;
   int           limit;
   int           val_errs = 0;
   int           cnt_errs = 0;
   int           prot_errs = 0;

   // nch sid cid secs tics trl sob eob seq vecs slow clr
   int tbl [NPKT][12] = '{
      '{1, 0, 0, 0, 0, 0, 1, 0, 0, 3, 0, 0},
      '{1, 1, 1, 1, 1, 1, 0, 0, 1, 4, 0, 0},
      '{2, 0, 0, 1, 1, 0, 0, 0, 2, 3, 0, 0},
      '{2, 1, 0, 0, 1, 1, 0, 0, 3, 2, 1, 0},
      '{4, 0, 1, 1, 0, 1, 0, 0, 4, 3, 1, 0},
      '{4, 1, 1, 1, 1, 1, 0, 1, 5, 2, 0, 0},
      '{4, 0, 0, 0, 0, 0, 1, 0, 7, 2, 0, 0},   // seqnum 6 skipped
      '{2, 0, 0, 1, 1, 0, 0, 1, 8, 3, 1, 0},
      '{1, 0, 0, 0, 0, 1, 1, 1, 0, 4, 0, 1}
   };

   always #50 clk = ~clk;

   vita_tx_deframer u_dut (
      .clk         (clk),
      .rst_n_i     (rst_n),
      .clear_i     (clear),
      .set_stb_i   (set_stb),
      .set_addr_i  (set_addr),
      .set_data_i  (set_data),
      .in_data_i   (in_data),
      .in_valid_i  (in_valid),
      .in_ready_o  (in_ready),
      .out_entry_o (out_entry),
      .out_valid_o (out_valid),
      .out_ready_i (out_ready)
   );

   always @(posedge clk)
   begin
      if (rst_n && out_valid && out_ready)
         exp_rd <= exp_rd + 1;
   end

   always @(posedge clk)
   begin
      #5;
      out_ready = ($urandom % 100) < ready_pct;
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > limit)
      begin
         $display("timeout after %0d cycles, entries still missing", cycles);
         $display("Simulation FAILED");
         $finish;
      end
   end

   a_entry_value: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && out_ready && (exp_rd != exp_wr))
         |-> (((out_entry ^ exp_entry[exp_rd]) & exp_mask[exp_rd]) == '0))
      else
      begin
         val_errs++;
         $display("ERR %0t: entry %0d differs from the expected vector", $time,
                  $sampled(exp_rd));
      end

   a_entry_extra: assert property (@(posedge clk) disable iff (!rst_n)
      (out_valid && out_ready) |-> (exp_rd != exp_wr))
      else
      begin
         cnt_errs++;
         $display("an entry left the fifo when none was expected");
      end

   a_store_block: assert property (@(posedge clk) disable iff (!rst_n)
      ((u_dut.state == vita_pkg::STORE) && !u_dut.fifo_space) |-> !in_ready)
      else
      begin
         prot_errs++;
         $display("input ready high while the store waits on a full fifo");
      end

   a_reset_idle: assert property (@(posedge clk) $rose(rst_n) |-> (!out_valid && in_ready))
      else
      begin
         prot_errs++;
         $display("ports not idle right after reset");
      end

   // header, optional words, payload and trailer
   function automatic int pkt_words(input int r);
      return 1 + tbl[r][1] + 2 * tbl[r][2] + tbl[r][3] + 2 * tbl[r][4] + tbl[r][5]
             + tbl[r][9] * tbl[r][0];
   endfunction

   task automatic send_word(input logic [31:0] data, input logic eof);
      int gap;
      begin
         gap = ($urandom % 4 == 0) ? ($urandom % 3) + 1 : 0;
         if (gap > 0)
         begin
            #5;
            in_valid = 1'b0;
            repeat (gap) @(posedge clk);
         end
         #5;
         in_data  = {2'b00, eof, 1'b0, data};
         in_valid = 1'b1;
         do
            @(posedge clk);
         while (!in_ready);
      end
   endtask

   // store cycle ends on the first edge with in_ready high, input ignored there
   task automatic wait_store();
      begin
         #5;
         in_valid = 1'b0;
         do
            @(posedge clk);
         while (!in_ready);
      end
   endtask

   task automatic write_numchan(input int nch);
      begin
         #5;
         set_stb  = 1'b1;
         set_addr = vita_pkg::NUMCHAN_ADDR;
         set_data = 32'(nch - 1);
         @(posedge clk);
         #5;
         set_stb = 1'b0;
         cur_nch = nch;
         @(posedge clk);
      end
   endtask

   task automatic send_packet(input int r);
      int           nch;
      int           nvec;
      logic [3:0]   seq;
      logic [31:0]  samp [16];
      logic [63:0]  tstamp;
      logic [31:0]  hdr;
      logic [W-1:0] e;
      logic [W-1:0] m;
      logic         err;
      begin
         nch    = tbl[r][0];
         nvec   = tbl[r][9];
         seq    = 4'(tbl[r][8]);
         tstamp = {(tbl[r][3] != 0) ? $urandom : 32'd0, (tbl[r][4] != 0) ? $urandom : 32'd0};
         err    = (seq != prev_seq + 4'd1);
         prev_seq = seq;
         for (int v = 0; v < nvec; v++)
         begin
            e = '0;
            m = '0;
            e[vita_pkg::TIME_LSB +: 64] = tstamp;
            e[vita_pkg::SEQ_LSB +: 16]  = {12'd0, seq};
            e[vita_pkg::EOP_BIT]        = (v == nvec - 1);
            e[vita_pkg::EOB_BIT]        = (tbl[r][7] != 0);
            e[vita_pkg::SOB_BIT]        = (tbl[r][6] != 0);
            e[vita_pkg::SEND_AT_BIT]    = (tbl[r][3] != 0);
            e[vita_pkg::SEQERR_BIT]     = err;
            m[vita_pkg::SAMPLE_LSB - 1:0] = '1;
            for (int c = 0; c < nch; c++)
            begin
               samp[v * nch + c] = $urandom;
               e[vita_pkg::SAMPLE_LSB + 32 * c +: 32] = samp[v * nch + c];
               m[vita_pkg::SAMPLE_LSB + 32 * c +: 32] = '1;
            end
            exp_entry[exp_wr] = e;
            exp_mask[exp_wr]  = m;
            exp_wr++;
         end
         ready_pct = (tbl[r][10] != 0) ? 10 : 70;   // slow rows fill the fifo
         hdr = {4'(tbl[r][1]), 1'(tbl[r][2]), 1'(tbl[r][5]), 1'(tbl[r][6]), 1'(tbl[r][7]),
                2'(tbl[r][3]), 2'(tbl[r][4]), seq, 16'(pkt_words(r))};
         send_word(hdr, 1'b0);
         if (tbl[r][1] != 0)
            send_word($urandom, 1'b0);   // stream id
         if (tbl[r][2] != 0)
         begin
            send_word($urandom, 1'b0);
            send_word($urandom, 1'b0);
         end
         if (tbl[r][3] != 0)
            send_word(tstamp[63:32], 1'b0);
         if (tbl[r][4] != 0)
         begin
            send_word($urandom, 1'b0);   // upper tics
            send_word(tstamp[31:0], 1'b0);
         end
         for (int i = 0; i < nvec * nch; i++)
         begin
            send_word(samp[i], (tbl[r][5] == 0) && (i == nvec * nch - 1));
            if (i % nch == nch - 1)
               wait_store();
         end
         if (tbl[r][5] != 0)
            send_word($urandom, 1'b1);   // trailer carries end of frame
         #5;
         in_valid = 1'b0;
         @(posedge clk);
      end
   endtask

   initial
   begin
      int total;
      void'($urandom(5518));
      total = 0;
      for (int r = 0; r < NPKT; r++)
         total += pkt_words(r);
      limit     = 40 * total;
      rst_n     = 1'b0;
      clear     = 1'b0;
      set_stb   = 1'b0;
      set_addr  = '0;
      set_data  = '0;
      in_data   = '0;
      in_valid  = 1'b0;
      out_ready = 1'b0;
      repeat (8) @(posedge clk);
      #5;
      rst_n = 1'b1;
      @(posedge clk);
      for (int r = 0; r < NPKT; r++)
      begin
         if (tbl[r][11] != 0)
         begin
            while (exp_rd != exp_wr)
               @(posedge clk);
            #5;
            clear = 1'b1;
            @(posedge clk);
            #5;
            clear    = 1'b0;
            prev_seq = 4'hf;   // seqnum 0 in order again
            @(posedge clk);
         end
         if (tbl[r][0] != cur_nch)
            write_numchan(tbl[r][0]);
         send_packet(r);
      end
      while (exp_rd != exp_wr)
         @(posedge clk);
      repeat (4) @(posedge clk);
      $display("errors: value %0d, count %0d, protocol %0d", val_errs, cnt_errs, prot_errs);
      if (val_errs + cnt_errs + prot_errs == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

/* source/vita_tx_deframer.sv */
`timescale 1ns/1ps

module vita_tx_deframer (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         clear_i,
   input  logic                         set_stb_i,
   input  logic [7:0]                   set_addr_i,
   input  logic [31:0]                  set_data_i,
   input  logic [35:0]                  in_data_i,
   input  logic                         in_valid_i,
   output logic                         in_ready_o,
   output logic [vita_pkg::ENTRY_W-1:0] out_entry_o,
   output logic                         out_valid_o,
   input  logic                         out_ready_i
);

   vita_pkg::vita_state_e        state;
   logic                         wr;
   logic                         fifo_space;
   logic                         in_take;   // word actually transferred
   logic [1:0]                   phase;
   logic                         vec_done;
   logic                         last_vec;
   logic                         hdr_streamid;
   logic                         hdr_classid;
   logic                         hdr_secs;
   logic                         hdr_tics;
   logic                         has_streamid;
   logic                         has_classid;
   logic                         has_secs;
   logic                         has_tics;
   logic                         has_trailer;
   logic [15:0]                  hdr_len;
   logic [vita_pkg::ENTRY_W-1:0] entry;

   assign in_take = in_valid_i & in_ready_o;

   vita_hdr_fsm u_fsm (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .in_valid_i     (in_valid_i),
      .has_streamid_i (has_streamid),
      .has_classid_i  (has_classid),
      .has_secs_i     (has_secs),
      .has_tics_i     (has_tics),
      .has_trailer_i  (has_trailer),
      .hdr_streamid_i (hdr_streamid),
      .hdr_classid_i  (hdr_classid),
      .hdr_secs_i     (hdr_secs),
      .hdr_tics_i     (hdr_tics),
      .vec_done_i     (vec_done),
      .last_vec_i     (last_vec),
      .fifo_space_i   (fifo_space),
      .state_o        (state),
      .wr_o           (wr),
      .in_ready_o     (in_ready_o)
   );

   vita_len_counter u_cnt (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .state_i    (state),
      .in_valid_i (in_take),
      .in_data_i  (in_data_i),
      .hdr_len_i  (hdr_len),
      .phase_o    (phase),
      .vec_done_o (vec_done),
      .last_vec_o (last_vec)
   );

   vita_sample_packer u_pack (
      .clk            (clk),
      .rst_n_i        (rst_n_i),
      .clear_i        (clear_i),
      .state_i        (state),
      .phase_i        (phase),
      .in_valid_i     (in_take),
      .in_data_i      (in_data_i),
      .last_vec_i     (last_vec),
      .hdr_streamid_o (hdr_streamid),
      .hdr_classid_o  (hdr_classid),
      .hdr_secs_o     (hdr_secs),
      .hdr_tics_o     (hdr_tics),
      .has_streamid_o (has_streamid),
      .has_classid_o  (has_classid),
      .has_secs_o     (has_secs),
      .has_tics_o     (has_tics),
      .has_trailer_o  (has_trailer),
      .hdr_len_o      (hdr_len),
      .entry_o        (entry)
   );

   vita_sample_fifo u_fifo (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .clear_i    (clear_i),
      .wr_i       (wr),
      .wr_data_i  (entry),
      .rd_ready_i (out_ready_i),
      .space_o    (fifo_space),
      .rd_data_o  (out_entry_o),
      .rd_valid_o (out_valid_o)
   );

endmodule

/* source/vita_sample_fifo.sv */
`timescale 1ns/1ps

module vita_sample_fifo (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         clear_i,
   input  logic                         wr_i,
   input  logic [vita_pkg::ENTRY_W-1:0] wr_data_i,
   input  logic                         rd_ready_i,
   output logic                         space_o,
   output logic [vita_pkg::ENTRY_W-1:0] rd_data_o,
   output logic                         rd_valid_o
);

   logic [vita_pkg::ENTRY_W-1:0]            mem_q [vita_pkg::FIFO_DEPTH];
   logic [$clog2(vita_pkg::FIFO_DEPTH)-1:0] wr_ptr_q;
   logic [$clog2(vita_pkg::FIFO_DEPTH)-1:0] rd_ptr_q;
   logic [$clog2(vita_pkg::FIFO_DEPTH):0]   count_q;
   logic                                    rd;

   assign space_o    = (count_q != vita_pkg::FIFO_DEPTH);
   assign rd_valid_o = (count_q != '0);
   assign rd_data_o  = mem_q[rd_ptr_q];
   assign rd         = rd_valid_o && rd_ready_i;

   always_ff @(posedge clk)
   begin
      if (wr_i)
         mem_q[wr_ptr_q] <= wr_data_i;
   end

   // depth is a power of two, pointers wrap on their own
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else if (clear_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_i)
            wr_ptr_q <= wr_ptr_q + 1'b1;
         if (rd)
            rd_ptr_q <= rd_ptr_q + 1'b1;
         case ({wr_i, rd})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n_i)
      wr_i |-> (count_q != vita_pkg::FIFO_DEPTH))
      else $error("write into a full sample fifo");

endmodule

/* source/vita_sample_packer.sv */
`timescale 1ns/1ps

module vita_sample_packer (
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  logic                         clear_i,
   input  vita_pkg::vita_state_e        state_i,
   input  logic [1:0]                   phase_i,
   input  logic                         in_valid_i,
   input  logic [35:0]                  in_data_i,
   input  logic                         last_vec_i,
   output logic                         hdr_streamid_o,
   output logic                         hdr_classid_o,
   output logic                         hdr_secs_o,
   output logic                         hdr_tics_o,
   output logic                         has_streamid_o,
   output logic                         has_classid_o,
   output logic                         has_secs_o,
   output logic                         has_tics_o,
   output logic                         has_trailer_o,
   output logic [15:0]                  hdr_len_o,
   output logic [vita_pkg::ENTRY_W-1:0] entry_o
);

   logic        hdr_take;
   logic        sob_q;
   logic        eob_q;
   logic [3:0]  seq_q;
   logic        seq_err_q;
   logic [3:0]  seq_in;
   logic [63:0] time_q;
   logic [31:0] samp_q [vita_pkg::MAX_CHAN];

   // decodes of whatever word is on the bus
   assign hdr_streamid_o = (in_data_i[vita_pkg::HDR_TYPE_MSB -: 4] == 4'b0001);
   assign hdr_classid_o  = in_data_i[vita_pkg::HDR_CLASS_BIT];
   assign hdr_secs_o     = (in_data_i[vita_pkg::HDR_TSI_LSB +: 2] != 2'b00);
   assign hdr_tics_o     = (in_data_i[vita_pkg::HDR_TSF_LSB +: 2] != 2'b00);
   assign seq_in         = in_data_i[vita_pkg::HDR_SEQ_LSB +: 4];

   assign hdr_take = (state_i == vita_pkg::HEADER) && in_valid_i;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         {has_streamid_o, has_classid_o, has_secs_o, has_tics_o} <= 4'd0;
         {has_trailer_o, sob_q, eob_q} <= 3'd0;
         seq_q     <= 4'hf;
         seq_err_q <= 1'b0;
      end
      else if (clear_i)
      begin
         seq_q     <= 4'hf;  // next packet with seqnum 0 is in order
         seq_err_q <= 1'b0;
      end
      else if (hdr_take)
      begin
         has_streamid_o <= hdr_streamid_o;
         has_classid_o  <= hdr_classid_o;
         has_secs_o     <= hdr_secs_o;
         has_tics_o     <= hdr_tics_o;
         has_trailer_o  <= in_data_i[vita_pkg::HDR_TRL_BIT];
         sob_q          <= in_data_i[vita_pkg::HDR_SOB_BIT];
         eob_q          <= in_data_i[vita_pkg::HDR_EOB_BIT];
         seq_q          <= seq_in;
         seq_err_q      <= (seq_in != seq_q + 4'd1);
      end
   end

   // header, streamid, classid pair, secs, tics pair, trailer
   assign hdr_len_o = 16'd1 + {15'd0, has_streamid_o} + {14'd0, has_classid_o, 1'b0}
                      + {15'd0, has_secs_o} + {14'd0, has_tics_o, 1'b0} + {15'd0, has_trailer_o};

   always_ff @(posedge clk)
   begin
      if (state_i == vita_pkg::HEADER)
         time_q <= 64'd0;
      else if (in_valid_i && (state_i == vita_pkg::SECS))
         time_q[63:32] <= in_data_i[31:0];
      else if (in_valid_i && (state_i == vita_pkg::TICS2))
         time_q[31:0] <= in_data_i[31:0];  // upper tics word is ignored
      if (in_valid_i && (state_i == vita_pkg::PAYLOAD))
         samp_q[phase_i] <= in_data_i[31:0];
   end

   always_comb
   begin
      entry_o = '0;
      entry_o[vita_pkg::TIME_LSB +: 64]  = time_q;
      entry_o[vita_pkg::SEQ_LSB +: 16]   = {12'd0, seq_q};
      entry_o[vita_pkg::EOP_BIT]         = last_vec_i;
      entry_o[vita_pkg::EOB_BIT]         = eob_q;
      entry_o[vita_pkg::SOB_BIT]         = sob_q;
      entry_o[vita_pkg::SEND_AT_BIT]     = has_secs_o;
      entry_o[vita_pkg::SEQERR_BIT]      = seq_err_q;
      for (int i = 0; i < vita_pkg::MAX_CHAN; i++)
         entry_o[vita_pkg::SAMPLE_LSB + 32 * i +: 32] = samp_q[i];
   end

   // no timestamp words, so the time stays cleared from the header
   a_zero_time: assert property (@(posedge clk) disable iff (!rst_n_i)
      ((state_i == vita_pkg::PAYLOAD) && !has_secs_o && !has_tics_o) |-> (time_q == 64'd0))
      else $error("stale timestamp in a packet without one");

endmodule

/* source/vita_len_counter.sv */
`timescale 1ns/1ps

module vita_len_counter (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  set_stb_i,
   input  logic [7:0]            set_addr_i,
   input  logic [31:0]           set_data_i,
   input  vita_pkg::vita_state_e state_i,
   input  logic                  in_valid_i,
   input  logic [35:0]           in_data_i,
   input  logic [15:0]           hdr_len_i,
   output logic [1:0]            phase_o,
   output logic                  vec_done_o,
   output logic                  last_vec_o
);

   logic [1:0]  numchan_q;   // channels minus one
   logic [15:0] remain_q;    // words left, header words included
   logic        eof_q;
   logic        pay_word;

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         numchan_q <= 2'd0;
      else if (set_stb_i && (set_addr_i == vita_pkg::NUMCHAN_ADDR))
         numchan_q <= set_data_i[1:0];
   end

   assign pay_word   = (state_i == vita_pkg::PAYLOAD) && in_valid_i;
   assign vec_done_o = (phase_o == numchan_q);

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         remain_q <= 16'd0;
         phase_o  <= 2'd0;
         eof_q    <= 1'b0;
      end
      else if (state_i == vita_pkg::HEADER)
      begin
         phase_o <= 2'd0;
         eof_q   <= 1'b0;
         if (in_valid_i)
            remain_q <= in_data_i[15:0];  // packet length field
      end
      else if (pay_word)
      begin
         if (in_data_i[vita_pkg::EOF_BIT])
            eof_q <= 1'b1;
         if (vec_done_o)
         begin
            phase_o  <= 2'd0;
            remain_q <= remain_q - ({14'd0, numchan_q} + 16'd1);  // one whole vector
         end
         else
            phase_o <= phase_o + 2'd1;
      end
   end

   // only header and trailer words left, or the frame ended early
   assign last_vec_o = eof_q || (remain_q == hdr_len_i);

   a_store_phase: assert property (@(posedge clk) disable iff (!rst_n_i)
      (state_i == vita_pkg::STORE) |-> (phase_o == 2'd0))
      else $error("store entered with a partial vector");

endmodule

/* source/vita_hdr_fsm.sv */
`timescale 1ns/1ps

module vita_hdr_fsm (
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  logic                  clear_i,
   input  logic                  in_valid_i,
   input  logic                  has_streamid_i,
   input  logic                  has_classid_i,
   input  logic                  has_secs_i,
   input  logic                  has_tics_i,
   input  logic                  has_trailer_i,
   input  logic                  hdr_streamid_i,
   input  logic                  hdr_classid_i,
   input  logic                  hdr_secs_i,
   input  logic                  hdr_tics_i,
   input  logic                  vec_done_i,
   input  logic                  last_vec_i,
   input  logic                  fifo_space_i,
   output vita_pkg::vita_state_e state_o,
   output logic                  wr_o,
   output logic                  in_ready_o
);

   vita_pkg::vita_state_e state_q;
   vita_pkg::vita_state_e state_d;
   logic                  pay_rdy_q;  // second cycle of a payload word
   logic                  take;

   // first optional word still ahead, else payload
   function automatic vita_pkg::vita_state_e next_opt(
      input logic classid,
      input logic secs,
      input logic tics
   );
      if (classid)
         return vita_pkg::CLASSID;
      else if (secs)
         return vita_pkg::SECS;
      else if (tics)
         return vita_pkg::TICS;
      else
         return vita_pkg::PAYLOAD;
   endfunction

   // one bubble per payload word, and no accept while a full fifo blocks the store
   always_comb
   begin
      if (state_q == vita_pkg::PAYLOAD)
         in_ready_o = pay_rdy_q;
      else
         in_ready_o = !((state_q == vita_pkg::STORE) && !fifo_space_i);
   end

   assign take = in_valid_i & in_ready_o;

   always_comb
   begin
      state_d = state_q;
      if (state_q == vita_pkg::STORE)
      begin
         if (fifo_space_i)
         begin
            if (!last_vec_i)
               state_d = vita_pkg::PAYLOAD;
            else if (has_trailer_i)
               state_d = vita_pkg::TRAILER;
            else
               state_d = vita_pkg::HEADER;
         end
      end
      else if (take)
      begin
         case (state_q)
            vita_pkg::HEADER:        // registered flags not yet valid here
               if (hdr_streamid_i)
                  state_d = vita_pkg::STREAMID;
               else
                  state_d = next_opt(hdr_classid_i, hdr_secs_i, hdr_tics_i);
            vita_pkg::STREAMID: state_d = next_opt(has_classid_i, has_secs_i, has_tics_i);
            vita_pkg::CLASSID:  state_d = vita_pkg::CLASSID2;
            vita_pkg::CLASSID2: state_d = next_opt(1'b0, has_secs_i, has_tics_i);
            vita_pkg::SECS:     state_d = next_opt(1'b0, 1'b0, has_tics_i);
            vita_pkg::TICS:     state_d = vita_pkg::TICS2;
            vita_pkg::TICS2:    state_d = vita_pkg::PAYLOAD;
            vita_pkg::PAYLOAD:
               if (vec_done_i)
                  state_d = vita_pkg::STORE;
            vita_pkg::TRAILER:  state_d = vita_pkg::HEADER;  // trailer dropped
            default:            state_d = vita_pkg::HEADER;
         endcase
      end
   end

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q   <= vita_pkg::HEADER;
         pay_rdy_q <= 1'b0;
      end
      else if (clear_i)
      begin
         state_q   <= vita_pkg::HEADER;
         pay_rdy_q <= 1'b0;
      end
      else
      begin
         state_q   <= state_d;
         pay_rdy_q <= (state_q == vita_pkg::PAYLOAD) && !take;
      end
   end

   assign state_o = state_q;
   assign wr_o    = (state_q == vita_pkg::STORE) && fifo_space_i;

   // one write per stored vector
   a_wr_single: assert property (@(posedge clk) disable iff (!rst_n_i)
      wr_o |=> !wr_o)
      else $error("two fifo writes for one vector");

endmodule

/* source/vita_pkg.sv */
package vita_pkg;

   // parser states, one per packet word type plus the store cycle
   typedef enum logic [3:0] {
      HEADER   = 4'd0,
      STREAMID = 4'd1,
      CLASSID  = 4'd2,
      CLASSID2 = 4'd3,
      SECS     = 4'd4,
      TICS     = 4'd5,
      TICS2    = 4'd6,
      PAYLOAD  = 4'd7,
      STORE    = 4'd8,
      TRAILER  = 4'd9
   } vita_state_e;

   localparam int MAX_CHAN = 4;        // channels per sample vector

   // flags + seqnum + time + samples
   localparam int ENTRY_W = 5 + 16 + 64 + 32 * MAX_CHAN;

   localparam logic [7:0] NUMCHAN_ADDR = 8'd0;

   localparam int FIFO_DEPTH = 4;

   // field positions inside one fifo entry
   localparam int TIME_LSB    = 0;     // 64 bits, secs in the upper half
   localparam int SEQ_LSB     = 64;    // 16 bits, only the low 4 carry the seqnum
   localparam int EOP_BIT     = 80;
   localparam int EOB_BIT     = 81;
   localparam int SOB_BIT     = 82;
   localparam int SEND_AT_BIT = 83;
   localparam int SEQERR_BIT  = 84;
   localparam int SAMPLE_LSB  = 85;    // channel 0 first

   // header word layout
   localparam int HDR_TYPE_MSB  = 31;
   localparam int HDR_CLASS_BIT = 27;
   localparam int HDR_TRL_BIT   = 26;
   localparam int HDR_SOB_BIT   = 25;
   localparam int HDR_EOB_BIT   = 24;
   localparam int HDR_TSI_LSB   = 22;
   localparam int HDR_TSF_LSB   = 20;
   localparam int HDR_SEQ_LSB   = 16;
   localparam int EOF_BIT       = 33;

endpackage
